// ==== flist.f ====
src/wb_bus_pkg.sv
src/xbar_map_pkg.sv
src/wb_req_if.sv
src/wb_addr_decode.sv
src/wb_target_port.sv
src/wb_rsp_route.sv
src/wb_xbar_top.sv
tests/tb_clkgen.sv
tests/tb_wb_xbar.sv

// ==== src/wb_addr_decode.sv ====
// Per-master address decoder, holds the selected target for the length of a cycle
`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode (
	input  wire logic                     clk,
	input  wire logic                     rstn,
	wb_req_if.xbar                        req,
	input  wire logic                     ack_i,
	input  wire logic                     err_i,
	output      xbar_map_pkg::target_id_t sel_target_o
);

	typedef enum logic {
		DEC_IDLE,
		DEC_BUSY
	} dec_state_e;

	dec_state_e               state_q;
	xbar_map_pkg::target_id_t sel_q;

	// Map lookup, lowest matching target wins
	function automatic xbar_map_pkg::target_id_t map_lookup(input wb_bus_pkg::wb_addr_t adr);
		xbar_map_pkg::target_id_t hit;
		hit = xbar_map_pkg::NO_TARGET;
		// Walk downwards so the last hit kept is the lowest id
		for (int t = xbar_map_pkg::N_TARGETS - 1; t >= 0; t--) begin
			if (adr >= xbar_map_pkg::TARGET_BASE[t] && adr <= xbar_map_pkg::TARGET_LIMIT[t]) begin
				hit = xbar_map_pkg::target_id_t'(t);
			end
		end
		return hit;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state_q <= DEC_IDLE;
			sel_q   <= xbar_map_pkg::TGT_IDLE;
		end else begin
			case (state_q)
				DEC_IDLE: begin
					// Latch the target on the first sampled strobe
					if (req.cyc && req.stb) begin
						state_q <= DEC_BUSY;
						sel_q   <= map_lookup(req.adr);
					end
				end
				DEC_BUSY: begin
					// Master sees its response on this edge
					if (ack_i || err_i) begin
						state_q <= DEC_IDLE;
						sel_q   <= xbar_map_pkg::TGT_IDLE;
					end
				end
				default: state_q <= DEC_IDLE;
			endcase
		end
	end

	assign sel_target_o = sel_q;

	// Router never answers with both ACK and ERR
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn) !(ack_i && err_i));

endmodule

`default_nettype wire

// ==== src/wb_bus_pkg.sv ====
// Wishbone bus package with the bus widths, the field types and the request struct
`default_nettype none

package wb_bus_pkg;

	// Bus widths
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	// One select per data byte
	localparam int WB_SEL_W  = WB_DATA_W / 8;

	// Field types
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_SEL_W-1:0]  wb_sel_t;

	// Master request as seen by a target, 71 bits
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat_w;
		wb_sel_t  sel;
	} wb_req_t;

endpackage

`default_nettype wire

// ==== src/wb_req_if.sv ====
// Wishbone master request bundle, from one master into the crossbar
`timescale 1ns/1ps
`default_nettype none

interface wb_req_if;

	// Cycle and strobe qualify the rest
	logic                 cyc;
	logic                 stb;
	logic                 we;
	wb_bus_pkg::wb_addr_t adr;
	wb_bus_pkg::wb_data_t dat_w;
	wb_bus_pkg::wb_sel_t  sel;

	// Master drives the request
	modport master (
		output cyc, stb, we, adr, dat_w, sel
	);

	// Decoders and target ports only read it
	modport xbar (
		input cyc, stb, we, adr, dat_w, sel
	);

endinterface

`default_nettype wire

// ==== src/wb_rsp_route.sv ====
// Per-master response router with the decode-fail ERR responder
`timescale 1ns/1ps
`default_nettype none

module wb_rsp_route #(
	parameter int MASTER_ID = 0
) (
	input  wire logic                     clk,
	input  wire logic                     rstn,
	input  wire xbar_map_pkg::target_id_t sel_target_i,
	input  wire logic                     gnt_i [xbar_map_pkg::N_TARGETS],
	input  wire xbar_map_pkg::master_id_t gnt_id_i [xbar_map_pkg::N_TARGETS],
	input  wire wb_bus_pkg::wb_data_t     t_dat_r_i [xbar_map_pkg::N_TARGETS],
	input  wire logic                     t_ack_i [xbar_map_pkg::N_TARGETS],
	input  wire logic                     t_err_i [xbar_map_pkg::N_TARGETS],
	output      logic                     ack_o,
	output      logic                     err_o,
	output      wb_bus_pkg::wb_data_t     dat_r_o
);

	logic                 route_ack;
	logic                 route_err;
	wb_bus_pkg::wb_data_t route_dat;
	// ACK from any target granted to this master, whatever it selects
	logic                 owned_ack;
	// Decode-fail one-shot
	logic                 fail_err_q;

	// Pass the selected target's reply once this master owns it
	always_comb begin
		route_ack = 1'b0;
		route_err = 1'b0;
		route_dat = '0;
		owned_ack = 1'b0;
		for (int t = 0; t < xbar_map_pkg::N_TARGETS; t++) begin
			if (gnt_i[t] && gnt_id_i[t] == xbar_map_pkg::master_id_t'(MASTER_ID)) begin
				owned_ack = owned_ack | t_ack_i[t];
			end
			if (sel_target_i == xbar_map_pkg::target_id_t'(t) && gnt_i[t] &&
				gnt_id_i[t] == xbar_map_pkg::master_id_t'(MASTER_ID)) begin
				route_ack = t_ack_i[t];
				route_err = t_err_i[t];
				route_dat = t_dat_r_i[t];
			end
		end
	end

	// High for one cycle, the cycle after the miss is latched
	always_ff @(posedge clk) begin
		if (!rstn) begin
			fail_err_q <= 1'b0;
		end else begin
			fail_err_q <= (sel_target_i == xbar_map_pkg::NO_TARGET) && !fail_err_q;
		end
	end

	assign ack_o   = route_ack;
	assign err_o   = route_err | fail_err_q;
	assign dat_r_o = route_dat;

	// A miss reaches no target, so no target can ACK it
	a_no_ack_on_miss: assert property (@(posedge clk) disable iff (!rstn)
		(sel_target_i == xbar_map_pkg::NO_TARGET) |-> !owned_ack);

endmodule

`default_nettype wire

// ==== src/wb_target_port.sv ====
// Per-target port, round-robin arbiter over the masters and request forwarder
`timescale 1ns/1ps
`default_nettype none

module wb_target_port #(
	parameter int TARGET_ID = 0
) (
	input  wire logic                     clk,
	input  wire logic                     rstn,
	wb_req_if.xbar                        m_req [xbar_map_pkg::N_MASTERS],
	input  wire xbar_map_pkg::target_id_t sel_target_i [xbar_map_pkg::N_MASTERS],
	output      logic                     gnt_o,
	output      xbar_map_pkg::master_id_t gnt_id_o,
	output      wb_bus_pkg::wb_req_t      t_req_o
);

	typedef logic [xbar_map_pkg::N_MASTERS-1:0] req_vec_t;

	// Requests flattened so they can be picked by a variable index
	wb_bus_pkg::wb_req_t      req_bus [xbar_map_pkg::N_MASTERS];
	req_vec_t                 req_bits;
	logic                     gnt_q;
	// Owner while granted, last grantee once released
	xbar_map_pkg::master_id_t gnt_id_q;
	xbar_map_pkg::master_id_t pick_id;
	xbar_map_pkg::master_id_t hi_id;
	xbar_map_pkg::master_id_t lo_id;
	logic                     found_hi;
	logic                     active;

	for (genvar m = 0; m < xbar_map_pkg::N_MASTERS; m++) begin : g_req
		assign req_bus[m] = {m_req[m].cyc, m_req[m].stb, m_req[m].we,
			m_req[m].adr, m_req[m].dat_w, m_req[m].sel};
		// Request bit follows the decoder directly
		assign req_bits[m] = (sel_target_i[m] == xbar_map_pkg::target_id_t'(TARGET_ID));
	end

	// Round robin pick
	always_comb begin
		hi_id    = '0;
		lo_id    = '0;
		found_hi = 1'b0;
		// Descending walk, so the lowest match is kept
		for (int m = xbar_map_pkg::N_MASTERS - 1; m >= 0; m--) begin
			if (req_bits[m]) begin
				lo_id = xbar_map_pkg::master_id_t'(m);
				if (m > int'(gnt_id_q)) begin
					hi_id    = xbar_map_pkg::master_id_t'(m);
					found_hi = 1'b1;
				end
			end
		end
		// First requester above the last grantee, else the lowest one
		pick_id = found_hi ? hi_id : lo_id;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q    <= 1'b0;
			// Start as if the top master went last, so master 0 goes first
			gnt_id_q <= xbar_map_pkg::master_id_t'(xbar_map_pkg::N_MASTERS - 1);
		end else if (gnt_q) begin
			// Hold until the owner's request drops
			if (!req_bits[gnt_id_q]) begin
				gnt_q <= 1'b0;
			end
		end else if (|req_bits) begin
			gnt_q    <= 1'b1;
			gnt_id_q <= pick_id;
		end
	end

	// Forward only while the owner still holds the target
	assign active = gnt_q && req_bits[gnt_id_q];

	always_comb begin
		t_req_o = '0;
		if (active) begin
			t_req_o = req_bus[gnt_id_q];
		end
	end

	assign gnt_o    = gnt_q;
	assign gnt_id_o = gnt_id_q;

	// Fresh grant lands on a master that was requesting
	a_gnt_to_req: assert property (@(posedge clk) disable iff (!rstn)
		$rose(gnt_q) |-> |(($past(req_bits) >> gnt_id_q) & req_vec_t'(1)));

	// Owner only changes across a released cycle
	a_gnt_owner_stable: assert property (@(posedge clk) disable iff (!rstn)
		(gnt_q ##1 gnt_q) |-> $stable(gnt_id_q));

endmodule

`default_nettype wire

// ==== src/wb_xbar_top.sv ====
// Two-master, four-target Wishbone crossbar top level
`timescale 1ns/1ps
`default_nettype none

module wb_xbar_top (
	input  wire logic                 clk,
	input  wire logic                 rstn,
	// Master side
	input  wire logic                 m_cyc_i   [xbar_map_pkg::N_MASTERS],
	input  wire logic                 m_stb_i   [xbar_map_pkg::N_MASTERS],
	input  wire logic                 m_we_i    [xbar_map_pkg::N_MASTERS],
	input  wire wb_bus_pkg::wb_addr_t m_adr_i   [xbar_map_pkg::N_MASTERS],
	input  wire wb_bus_pkg::wb_data_t m_dat_w_i [xbar_map_pkg::N_MASTERS],
	input  wire wb_bus_pkg::wb_sel_t  m_sel_i   [xbar_map_pkg::N_MASTERS],
	output      wb_bus_pkg::wb_data_t m_dat_r_o [xbar_map_pkg::N_MASTERS],
	output      logic                 m_ack_o   [xbar_map_pkg::N_MASTERS],
	output      logic                 m_err_o   [xbar_map_pkg::N_MASTERS],
	// Target side
	output      logic                 t_cyc_o   [xbar_map_pkg::N_TARGETS],
	output      logic                 t_stb_o   [xbar_map_pkg::N_TARGETS],
	output      logic                 t_we_o    [xbar_map_pkg::N_TARGETS],
	output      wb_bus_pkg::wb_addr_t t_adr_o   [xbar_map_pkg::N_TARGETS],
	output      wb_bus_pkg::wb_data_t t_dat_w_o [xbar_map_pkg::N_TARGETS],
	output      wb_bus_pkg::wb_sel_t  t_sel_o   [xbar_map_pkg::N_TARGETS],
	input  wire wb_bus_pkg::wb_data_t t_dat_r_i [xbar_map_pkg::N_TARGETS],
	input  wire logic                 t_ack_i   [xbar_map_pkg::N_TARGETS],
	input  wire logic                 t_err_i   [xbar_map_pkg::N_TARGETS]
);

	// One request bundle per master
	wb_req_if m_req_if [xbar_map_pkg::N_MASTERS] ();

	xbar_map_pkg::target_id_t sel_target [xbar_map_pkg::N_MASTERS];
	logic                     gnt        [xbar_map_pkg::N_TARGETS];
	xbar_map_pkg::master_id_t gnt_id     [xbar_map_pkg::N_TARGETS];
	wb_bus_pkg::wb_req_t      t_req      [xbar_map_pkg::N_TARGETS];

	// Master side, decode and response routing
	for (genvar m = 0; m < xbar_map_pkg::N_MASTERS; m++) begin : g_master
		assign m_req_if[m].cyc   = m_cyc_i[m];
		assign m_req_if[m].stb   = m_stb_i[m];
		assign m_req_if[m].we    = m_we_i[m];
		assign m_req_if[m].adr   = m_adr_i[m];
		assign m_req_if[m].dat_w = m_dat_w_i[m];
		assign m_req_if[m].sel   = m_sel_i[m];

		wb_addr_decode u_decode (
			.clk          (clk),
			.rstn         (rstn),
			.req          (m_req_if[m]),
			.ack_i        (m_ack_o[m]),
			.err_i        (m_err_o[m]),
			.sel_target_o (sel_target[m])
		);

		wb_rsp_route #(
			.MASTER_ID (m)
		) u_route (
			.clk          (clk),
			.rstn         (rstn),
			.sel_target_i (sel_target[m]),
			.gnt_i        (gnt),
			.gnt_id_i     (gnt_id),
			.t_dat_r_i    (t_dat_r_i),
			.t_ack_i      (t_ack_i),
			.t_err_i      (t_err_i),
			.ack_o        (m_ack_o[m]),
			.err_o        (m_err_o[m]),
			.dat_r_o      (m_dat_r_o[m])
		);
	end

	// Target side, arbitration and forwarding
	for (genvar t = 0; t < xbar_map_pkg::N_TARGETS; t++) begin : g_target
		wb_target_port #(
			.TARGET_ID (t)
		) u_port (
			.clk          (clk),
			.rstn         (rstn),
			.m_req        (m_req_if),
			.sel_target_i (sel_target),
			.gnt_o        (gnt[t]),
			.gnt_id_o     (gnt_id[t]),
			.t_req_o      (t_req[t])
		);

		// Unpack the forwarded request onto the target pins
		assign t_cyc_o[t]   = t_req[t].cyc;
		assign t_stb_o[t]   = t_req[t].stb;
		assign t_we_o[t]    = t_req[t].we;
		assign t_adr_o[t]   = t_req[t].adr;
		assign t_dat_w_o[t] = t_req[t].dat_w;
		assign t_sel_o[t]   = t_req[t].sel;
	end

endmodule

`default_nettype wire

// ==== src/xbar_map_pkg.sv ====
// Crossbar topology package with the id types and the target address map
`default_nettype none

package xbar_map_pkg;

	// Topology
	localparam int N_MASTERS = 2;
	localparam int N_TARGETS = 4;

	// Master index
	typedef logic [0:0] master_id_t;
	// Target index, wide enough for the extra codes below
	typedef logic [2:0] target_id_t;

	// Address hit no target, answered with ERR by the router
	localparam target_id_t NO_TARGET = 3'd4;
	// Decoder holds no cycle at all
	localparam target_id_t TGT_IDLE  = 3'd7;

	// Inclusive address ranges, checked in target order
	localparam wb_bus_pkg::wb_addr_t TARGET_BASE [N_TARGETS] = '{
		32'h0000_0000,
		32'h0000_1000,
		32'h0001_0000,
		32'h8000_0000
	};
	localparam wb_bus_pkg::wb_addr_t TARGET_LIMIT [N_TARGETS] = '{
		32'h0000_0FFF,
		32'h0000_1FFF,
		32'h0001_FFFF,
		32'h8000_00FF
	};

endpackage

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
// Testbench clock and reset source, 10 ns clock with a synchronous low reset
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int RST_CYCLES = 5
) (
	output logic clk_o,
	output logic rstn_o
);

	// 5 ns high, 5 ns low
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// Reset held low for RST_CYCLES rising edges, released on a falling edge
	initial begin
		rstn_o = 1'b0;
		repeat (RST_CYCLES) @(negedge clk_o);
		rstn_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/tb_wb_xbar.sv ====
// Crossbar testbench with two master drivers, four target models and file-driven checks
`timescale 1ns/1ps
`default_nettype none

module tb_wb_xbar;

	localparam int RST_CYCLES      = 5;
	localparam int CYCLES_PER_LINE = 40;
	localparam int NO_TGT          = 4;

	logic        clk;
	logic        rstn;
	// Master side of the DUT
	logic        m_cyc [2];
	logic        m_stb [2];
	logic        m_we [2];
	logic [31:0] m_adr [2];
	logic [31:0] m_wdat [2];
	logic [3:0]  m_sel [2];
	logic [31:0] m_rdat [2];
	logic        m_ack [2];
	logic        m_err [2];
	// Target side of the DUT
	logic        t_cyc [4];
	logic        t_stb [4];
	logic        t_we [4];
	logic [31:0] t_adr [4];
	logic [31:0] t_wdat [4];
	logic [3:0]  t_sel [4];
	logic [31:0] t_rdat [4];
	logic        t_ack [4];
	logic        t_err [4];
	// Target models, memory word picked by address bits 7:2
	logic [31:0] mem [4][64];
	logic        busy [4];
	int          wait_cnt [4];
	int          last_served [4];
	// Current stimulus line per master
	string       s_name [2];
	string       s_exp [2];
	logic        s_we [2];
	logic [31:0] s_adr [2];
	logic [31:0] s_dat [2];
	logic [3:0]  s_sel [2];
	logic        inflight [2];
	int          cycles = 0;
	int          limit = 0;

	tb_clkgen #(.RST_CYCLES(RST_CYCLES)) u_clkgen (.clk_o(clk), .rstn_o(rstn));

	wb_xbar_top dut0 (
		.clk       (clk),
		.rstn      (rstn),
		.m_cyc_i   (m_cyc),
		.m_stb_i   (m_stb),
		.m_we_i    (m_we),
		.m_adr_i   (m_adr),
		.m_dat_w_i (m_wdat),
		.m_sel_i   (m_sel),
		.m_dat_r_o (m_rdat),
		.m_ack_o   (m_ack),
		.m_err_o   (m_err),
		.t_cyc_o   (t_cyc),
		.t_stb_o   (t_stb),
		.t_we_o    (t_we),
		.t_adr_o   (t_adr),
		.t_dat_w_o (t_wdat),
		.t_sel_o   (t_sel),
		.t_dat_r_i (t_rdat),
		.t_ack_i   (t_ack),
		.t_err_i   (t_err)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopped at the first error");
	endtask

	// Crossbar address map, NO_TGT for a hole
	function automatic int addr_target(input logic [31:0] a);
		if (a <= 32'h0000_0fff) return 0;
		if (a >= 32'h0000_1000 && a <= 32'h0000_1fff) return 1;
		if (a >= 32'h0001_0000 && a <= 32'h0001_ffff) return 2;
		if (a >= 32'h8000_0000 && a <= 32'h8000_00ff) return 3;
		return NO_TGT;
	endfunction

	task automatic check_bus_idle(input string when_s);
		for (int t = 0; t < 4; t++) begin
			assert (!t_cyc[t] && !t_stb[t]) else report_error({"Target cycle active ", when_s});
		end
		for (int m = 0; m < 2; m++) begin
			assert (!m_ack[m] && !m_err[m]) else report_error({"Master response active ", when_s});
		end
	endtask

	// One classic cycle for master m, then the checks of its line
	task automatic run_line(input int m);
		logic        got_ack;
		logic        got_err;
		logic [31:0] got_dat;
		logic [31:0] exp_dat;
		@(negedge clk);
		m_cyc[m]  <= 1'b1;
		m_stb[m]  <= 1'b1;
		m_we[m]   <= s_we[m];
		m_adr[m]  <= s_adr[m];
		m_wdat[m] <= s_dat[m];
		m_sel[m]  <= s_sel[m];
		inflight[m] = 1'b1;
		// Sampled on the rising edge, bounded by the watchdog
		do begin
			@(posedge clk);
			got_ack = m_ack[m];
			got_err = m_err[m];
			got_dat = m_rdat[m];
		end while (!got_ack && !got_err);
		inflight[m] = 1'b0;
		@(negedge clk);
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
		if (s_exp[m] == "ERR") begin
			assert (got_err && !got_ack) else report_error($sformatf(
				"FAIL %s: expected ERR, actual ack=%b err=%b", s_name[m], got_ack, got_err));
		end else begin
			assert (got_ack && !got_err) else report_error($sformatf(
				"FAIL %s: expected ACK, actual ack=%b err=%b", s_name[m], got_ack, got_err));
			if (!s_we[m]) begin
				void'($sscanf(s_exp[m], "%h", exp_dat));
				assert (got_dat === exp_dat) else report_error($sformatf(
					"FAIL %s: expected %h, actual %h", s_name[m], exp_dat, got_dat));
			end
		end
	endtask

	// Target models answer on the falling edge after a 0 to 3 cycle wait
	initial begin
		int          hit;
		int          idx;
		logic [31:0] seed;
		// Wait lengths drawn from this process only
		seed = 32'hd06c2d9f;
		void'($urandom(seed));
		forever begin
			@(negedge clk);
			for (int t = 0; t < 4; t++) begin
				if (t_ack[t]) begin
					t_ack[t] <= 1'b0;
				end else if (rstn && t_cyc[t]) begin
					if (!busy[t]) begin
						// New access must be some master's request for this target
						hit = -1;
						for (int m = 0; m < 2; m++) begin
							if (inflight[m] && addr_target(s_adr[m]) == t && t_stb[t] &&
								t_adr[t] == s_adr[m] && t_we[t] == s_we[m] &&
								t_sel[t] == s_sel[m] && (!s_we[m] || t_wdat[t] == s_dat[m])) begin
								hit = m;
							end
						end
						assert (hit >= 0) else report_error($sformatf(
							"Target %0d saw a cycle that matches no master request", t));
						// Both masters waiting on this target, grant has to rotate
						if (inflight[0] && inflight[1] && addr_target(s_adr[0]) == t &&
							addr_target(s_adr[1]) == t && last_served[t] >= 0) begin
							assert (hit != last_served[t]) else report_error($sformatf(
								"Target %0d served master %0d twice in a row", t, hit));
						end
						last_served[t] = hit;
						busy[t] = 1'b1;
						wait_cnt[t] = $urandom % 4;
					end
					if (wait_cnt[t] == 0) begin
						idx = t_adr[t][7:2];
						// Byte lanes written only where selected
						for (int b = 0; b < 4; b++) begin
							if (t_we[t] && t_sel[t][b]) begin
								mem[t][idx][8*b +: 8] = t_wdat[t][8*b +: 8];
							end
						end
						t_rdat[t] <= mem[t][idx];
						t_ack[t]  <= 1'b1;
						busy[t] = 1'b0;
					end else begin
						wait_cnt[t] = wait_cnt[t] - 1;
					end
				end
			end
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		assert (limit == 0 || cycles < limit) else report_error($sformatf(
			"Timeout, the stimulus did not complete within %0d cycles", limit));
	end

	initial begin
		int          fd;
		int          n;
		int          n_lines;
		int          m;
		string       line;
		string       name;
		string       op;
		string       exp_s;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
		for (int i = 0; i < 2; i++) begin
			m_cyc[i]    = 1'b0;
			m_stb[i]    = 1'b0;
			m_we[i]     = 1'b0;
			m_adr[i]    = '0;
			m_wdat[i]   = '0;
			m_sel[i]    = '0;
			inflight[i] = 1'b0;
		end
		for (int t = 0; t < 4; t++) begin
			t_ack[t]       = 1'b0;
			t_err[t]       = 1'b0;
			t_rdat[t]      = '0;
			busy[t]        = 1'b0;
			wait_cnt[t]    = 0;
			last_served[t] = -1;
		end
		// Quiet bus through reset and one cycle beyond
		repeat (RST_CYCLES) begin
			@(negedge clk);
			check_bus_idle("during reset");
		end
		@(negedge clk);
		check_bus_idle("in the first cycle after reset");
		// First pass counts the lines, which sizes the timeout
		n_lines = 0;
		fd = $fopen("tests/xbar_stim.txt", "r");
		assert (fd != 0) else report_error("Cannot open the stimulus file tests/xbar_stim.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			name = "#";
			n = $sscanf(line, "%s", name);
			if (n == 1 && name != "#") begin
				n_lines++;
			end
		end
		$fclose(fd);
		limit = CYCLES_PER_LINE * n_lines + RST_CYCLES;
		fd = $fopen("tests/xbar_stim.txt", "r");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			name = "#";
			n = $sscanf(line, "%s %d %s %h %h %h %s", name, m, op, adr, dat, sel, exp_s);
			if (n >= 1 && name != "#") begin
				assert (n == 7 && m >= 0 && m < 2) else report_error({"Malformed stimulus line ", line});
				s_name[m] = name;
				s_we[m]   = (op == "wr" || op == "pwr");
				s_adr[m]  = adr;
				s_dat[m]  = dat;
				s_sel[m]  = sel;
				s_exp[m]  = exp_s;
				if (op == "pwr" || op == "prd") begin
					// Pair starts once its master 1 half is loaded
					if (m == 1) begin
						fork
							run_line(0);
							run_line(1);
						join
					end
				end else begin
					run_line(m);
				end
			end
		end
		$fclose(fd);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/xbar_stim.txt ====
# name master op address wdata sel expect
# op is wr, rd, or pwr and prd for a concurrent pair; expect is ACK, ERR or read data
map_t0_base_wr   0 wr  00000000 a0a0a001 f ACK
map_t0_limit_wr  0 wr  00000ffc a0a0a0ff f ACK
map_t1_base_wr   0 wr  00001000 b1b1b101 f ACK
map_t1_limit_wr  0 wr  00001ffc b1b1b1ff f ACK
map_t2_base_wr   0 wr  00010000 c2c2c201 f ACK
map_t2_limit_wr  0 wr  0001fffc c2c2c2ff f ACK
map_t3_base_wr   0 wr  80000000 d3d3d301 f ACK
map_t3_limit_wr  0 wr  800000fc d3d3d3ff f ACK
map_t0_base_rd   0 rd  00000000 00000000 f a0a0a001
map_t1_limit_rd  0 rd  00001ffc 00000000 f b1b1b1ff
map_t2_base_rd   0 rd  00010000 00000000 f c2c2c201
map_t3_limit_rd  0 rd  800000fc 00000000 f d3d3d3ff
unmapped_m0_wr   0 wr  00002000 deadbeef f ERR
unmapped_m1_rd   1 rd  80000100 00000000 f ERR
par_m0_t1_wr     0 pwr 00001104 12340001 f ACK
par_m1_t2_wr     1 pwr 00010108 56780002 f ACK
par_m0_t1_rd     0 prd 00001104 00000000 f 12340001
par_m1_t2_rd     1 prd 00010108 00000000 f 56780002
rr_m0_t0_wr      0 pwr 00000010 5a5a0010 f ACK
rr_m1_t0_wr      1 pwr 00000020 5a5a0020 f ACK
rr_m0_t0_rd      0 prd 00000010 00000000 f 5a5a0010
rr_m1_t0_rd      1 prd 00000020 00000000 f 5a5a0020
sel_full_wr      0 wr  80000040 11223344 f ACK
sel_low_wr       0 wr  80000040 aabbccdd 3 ACK
sel_top_wr       0 wr  80000040 eeeeeeee 8 ACK
sel_merged_rd    0 rd  80000040 00000000 f ee22ccdd
